// File: src/merge_defs.svh
// ****************************************
// merge parameters
// widths, queue depth and fall-through mode
// shared by the package and the top level
// ****************************************

`ifndef MERGE_DEFS_SVH
`define MERGE_DEFS_SVH

// width of one payload word
`define MERGE_DATA_WIDTH 16

// entries held by each channel queue
`define MERGE_FIFO_DEPTH 4

// fill level width, must hold the value of the depth itself
`define MERGE_LEVEL_WIDTH 3

// queue fall-through mode, 0 means registered head
`define MERGE_FALL_THROUGH 1'b0

`endif

// File: src/merge_pkg.sv
// ****************************************
// merge package
// payload, level and tag types of the
// two-channel stream merger
// ****************************************

`include "merge_defs.svh"

package merge_pkg;

    // one payload word as pushed by a producer
    typedef logic [`MERGE_DATA_WIDTH-1:0] data_t;

    // fill level of one queue
    typedef logic [`MERGE_LEVEL_WIDTH-1:0] level_t;

    // channel index, 0 is channel A and 1 is channel B
    typedef logic chan_t;

    // merged output word, tag in the upper bits
    typedef struct packed {
        chan_t src;
        data_t data;
    } beat_t;

    // channel that wins the next tie
    typedef enum logic {
        PRIO_A = 1'b0,
        PRIO_B = 1'b1
    } arb_state_e;

endpackage

// File: src/fifo_queue.sv
// ****************************************
// fifo queue
// circular buffer with sync flush, optional
// fall-through, full/empty flags and level
// ****************************************

`timescale 1ns/1ps

module fifo_queue #(
    // number of entries, at least 1
    parameter int unsigned DEPTH        = 8,
    // forward the input word when pushing into an empty queue
    parameter bit          FALL_THROUGH = 1'b0,
    // pointer width, derived from the depth
    parameter int unsigned PTR_W        = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    // producer side
    input  logic                push_i,
    input  merge_pkg::data_t    data_i,
    // consumer side
    input  logic                pop_i,
    output merge_pkg::data_t    data_o,
    // status
    output logic                full_o,
    output logic                empty_o,
    output logic [PTR_W:0]      level_o
);

    // last valid pointer value, wrap point of both pointers
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    // occupancy when full
    localparam logic [PTR_W:0]   FULL_CNT = (PTR_W + 1)'(DEPTH);

    // storage, no reset on the payload
    merge_pkg::data_t mem_q [DEPTH];

    logic [PTR_W-1:0] rd_ptr_q, rd_ptr_n;
    logic [PTR_W-1:0] wr_ptr_q, wr_ptr_n;
    // one bit wider than the pointer so a full queue shows its real count
    logic [PTR_W:0]   cnt_q, cnt_n;

    // accepted push and pop
    logic push_ok;
    logic pop_ok;
    // memory write enable, the remains of the clock gate
    logic mem_we;

    // advance a pointer with wrap at the last entry
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == LAST_PTR) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // status flags
    assign full_o  = (cnt_q == FULL_CNT);
    // in fall-through mode a push into an empty queue is already visible
    assign empty_o = (cnt_q == '0) & ~(FALL_THROUGH & push_i);
    assign level_o = cnt_q;

    // a push while full or a pop while empty is dropped
    assign push_ok = push_i & ~full_o;
    assign pop_ok  = pop_i & ~empty_o;
    assign mem_we  = push_ok;

    always_comb begin
        rd_ptr_n = rd_ptr_q;
        wr_ptr_n = wr_ptr_q;
        cnt_n    = cnt_q;
        // head of the queue by default
        data_o   = mem_q[rd_ptr_q];

        if (push_ok) begin
            wr_ptr_n = next_ptr(wr_ptr_q);
            cnt_n    = cnt_q + 1'b1;
        end

        if (pop_ok) begin
            rd_ptr_n = next_ptr(rd_ptr_q);
            cnt_n    = cnt_q - 1'b1;
        end

        // push and pop together leave the count alone
        if (push_ok && pop_ok) begin
            cnt_n = cnt_q;
        end

        // bypass path for an empty queue
        if (FALL_THROUGH && (cnt_q == '0) && push_i) begin
            data_o = data_i;
            // word goes straight through, nothing is stored
            if (pop_i) begin
                rd_ptr_n = rd_ptr_q;
                wr_ptr_n = wr_ptr_q;
                cnt_n    = cnt_q;
            end
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin
            // sync flush drops all stored words
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_n;
            wr_ptr_q <= wr_ptr_n;
            cnt_q    <= cnt_n;
        end
    end

    // storage write, only on an accepted push
    always_ff @(posedge clk_i) begin
        if (mem_we) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

// File: src/stream_merger.sv
// ****************************************
// stream merger
// round-robin pick between two queue heads,
// registered beat tagged with its channel
// ****************************************

`timescale 1ns/1ps

module stream_merger (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    // stops popping while high
    input  logic                hold_i,
    // queue heads
    input  merge_pkg::data_t    head_a_i,
    input  logic                empty_a_i,
    input  merge_pkg::data_t    head_b_i,
    input  logic                empty_b_i,
    // pop strobes back to the queues
    output logic                pop_a_o,
    output logic                pop_b_o,
    // merged output
    output merge_pkg::beat_t    beat_o,
    output logic                out_valid_o
);

    // channel that wins the next tie
    merge_pkg::arb_state_e state_q, state_n;

    // a head counts only when there is no hold
    logic avail_a;
    logic avail_b;
    logic grant_a;
    logic grant_b;

    // next beat before the output register
    merge_pkg::beat_t beat_n;
    merge_pkg::beat_t beat_q;
    logic             valid_q;

    assign avail_a = ~empty_a_i & ~hold_i;
    assign avail_b = ~empty_b_i & ~hold_i;

    // A wins when alone or when it holds the priority
    assign grant_a = avail_a & (~avail_b | (state_q == merge_pkg::PRIO_A));
    // B takes whatever A leaves
    assign grant_b = avail_b & ~grant_a;

    // pops only ever hit a non-empty queue
    assign pop_a_o = grant_a;
    assign pop_b_o = grant_b;

    always_comb begin
        state_n = state_q;
        // priority moves to the channel that lost or was idle
        if (grant_a) begin
            state_n = merge_pkg::PRIO_B;
        end else if (grant_b) begin
            state_n = merge_pkg::PRIO_A;
        end
    end

    // tag and word of the granted channel
    always_comb begin
        beat_n.src  = merge_pkg::chan_t'(grant_b);
        beat_n.data = grant_b ? head_b_i : head_a_i;
    end

    // arbiter state and output valid
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= merge_pkg::PRIO_A;
            valid_q <= 1'b0;
        end else if (flush_i) begin
            // back to the reset priority, pending beat dropped
            state_q <= merge_pkg::PRIO_A;
            valid_q <= 1'b0;
        end else begin
            state_q <= state_n;
            valid_q <= grant_a | grant_b;
        end
    end

    // payload register, loaded only on a grant
    always_ff @(posedge clk_i) begin
        if (grant_a || grant_b) begin
            beat_q <= beat_n;
        end
    end

    assign beat_o      = beat_q;
    assign out_valid_o = valid_q;

endmodule

// File: src/dual_stream_merge_top.sv
// ****************************************
// dual stream merge top
// two channel queues feeding one
// round-robin merger
// ****************************************

`timescale 1ns/1ps

`include "merge_defs.svh"

module dual_stream_merge_top (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    input  logic                hold_i,
    // channel A producer
    input  logic                push_a_i,
    input  merge_pkg::data_t    data_a_i,
    output logic                full_a_o,
    output merge_pkg::level_t   level_a_o,
    // channel B producer
    input  logic                push_b_i,
    input  merge_pkg::data_t    data_b_i,
    output logic                full_b_o,
    output merge_pkg::level_t   level_b_o,
    // merged stream
    output merge_pkg::beat_t    beat_o,
    output logic                out_valid_o
);

    // queue heads towards the merger
    merge_pkg::data_t head_a;
    merge_pkg::data_t head_b;
    logic             empty_a;
    logic             empty_b;
    // pop strobes from the merger
    logic             pop_a;
    logic             pop_b;

    // channel A queue
    fifo_queue #(
        .DEPTH        (`MERGE_FIFO_DEPTH),
        .FALL_THROUGH (`MERGE_FALL_THROUGH)
    ) u_fifo_a (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .push_i  (push_a_i),
        .data_i  (data_a_i),
        .pop_i   (pop_a),
        .data_o  (head_a),
        .full_o  (full_a_o),
        .empty_o (empty_a),
        .level_o (level_a_o)
    );

    // channel B queue
    fifo_queue #(
        .DEPTH        (`MERGE_FIFO_DEPTH),
        .FALL_THROUGH (`MERGE_FALL_THROUGH)
    ) u_fifo_b (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .push_i  (push_b_i),
        .data_i  (data_b_i),
        .pop_i   (pop_b),
        .data_o  (head_b),
        .full_o  (full_b_o),
        .empty_o (empty_b),
        .level_o (level_b_o)
    );

    // round-robin merge of both heads
    stream_merger u_merger (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .hold_i      (hold_i),
        .head_a_i    (head_a),
        .empty_a_i   (empty_a),
        .head_b_i    (head_b),
        .empty_b_i   (empty_b),
        .pop_a_o     (pop_a),
        .pop_b_o     (pop_b),
        .beat_o      (beat_o),
        .out_valid_o (out_valid_o)
    );

endmodule

// File: verification/merge_clock_gen.sv
// ****************************************
// merge clock generator
// free-running testbench clock and an
// active low reset held for a few cycles
// ****************************************

`timescale 1ns/1ps

module merge_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_no
);

    // half period toggle
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset released on a rising edge
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

// File: verification/merge_tb.sv
// ****************************************
// merge testbench
// drives both producers and checks the merged
// stream against per-channel scoreboards
// ****************************************

`timescale 1ns/1ps

`include "merge_defs.svh"

module merge_tb;

    localparam int PERIOD_NS    = 10;
    localparam int RESET_CYCLES = 16;
    localparam int DEPTH        = `MERGE_FIFO_DEPTH;
    // cycles of random traffic
    localparam int RAND_CYCLES  = 400;
    // longest wait for a beat or a drain
    localparam int WAIT_LIMIT   = 100;
    // six tests with a wait limit and some stimulus each plus a margin
    localparam int WATCHDOG_CYCLES =
        RESET_CYCLES + RAND_CYCLES + 6 * (WAIT_LIMIT + 4 * DEPTH) + 200;
    // word pushed after the flush and far from the preloaded ones
    localparam merge_pkg::data_t FRESH_WORD = 16'h5a3c;

    logic              clk;
    logic              rst_n;
    logic              flush;
    logic              hold;
    logic              push_a;
    logic              push_b;
    merge_pkg::data_t  data_a;
    merge_pkg::data_t  data_b;
    logic              full_a;
    logic              full_b;
    merge_pkg::level_t level_a;
    merge_pkg::level_t level_b;
    merge_pkg::beat_t  beat;
    logic              out_valid;

    // words accepted by each queue and not yet seen on the output
    merge_pkg::data_t  sb_a[$];
    merge_pkg::data_t  sb_b[$];

    integer            seed;
    int                err_count    = 0;
    int                tests_run    = 0;
    int                tests_failed = 0;
    int                beat_count   = 0;
    merge_pkg::beat_t  last_beat;
    // alternation check armed by the fairness test only
    logic              fair_en      = 1'b0;
    merge_pkg::chan_t  fair_next;
    // hold and flush as sampled by the last edge
    logic              prev_hold    = 1'b0;
    logic              prev_flush   = 1'b0;

    merge_clock_gen #(
        .PERIOD_NS    (PERIOD_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    dual_stream_merge_top u_dual_stream_merge_top (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .flush_i     (flush),
        .hold_i      (hold),
        .push_a_i    (push_a),
        .data_a_i    (data_a),
        .full_a_o    (full_a),
        .level_a_o   (level_a),
        .push_b_i    (push_b),
        .data_b_i    (data_b),
        .full_b_o    (full_b),
        .level_b_o   (level_b),
        .beat_o      (beat),
        .out_valid_o (out_valid)
    );

    task automatic mismatch(input string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        err_count++;
    endtask

    task automatic fail_check(input string msg);
        $display("Error at %0t: %s", $time, msg);
        err_count++;
    endtask

    function automatic logic rand_bit();
        integer r;
        r = $random(seed);
        return r[0];
    endfunction

    function automatic merge_pkg::data_t rand_word();
        integer r;
        r = $random(seed);
        return merge_pkg::data_t'(r);
    endfunction

    // output beat against the head of its channel scoreboard
    task automatic check_beat();
        merge_pkg::data_t want;
        if (out_valid) begin
            beat_count++;
            last_beat = beat;
            if (fair_en) begin
                assert (beat.src == fair_next) else
                    mismatch($sformatf("beat from channel %0d, expected %0d",
                                       beat.src, fair_next));
                fair_next = ~fair_next;
            end
            if ((beat.src == 1'b0) ? (sb_a.size() == 0) : (sb_b.size() == 0)) begin
                fail_check($sformatf("beat on channel %0d with no word outstanding",
                                     beat.src));
            end else begin
                want = (beat.src == 1'b0) ? sb_a.pop_front() : sb_b.pop_front();
                assert (beat.data == want) else
                    mismatch($sformatf("channel %0d data %h, expected %h",
                                       beat.src, beat.data, want));
            end
        end
    endtask

    // level follows the scoreboard and full is high exactly at depth
    task automatic check_channel(input string name, input int level, input logic full,
                                 input int expected);
        assert (level == expected) else
            mismatch($sformatf("level %s is %0d, expected %0d", name, level, expected));
        assert (full == (expected == DEPTH)) else
            mismatch($sformatf("full %s is %0b with %0d words held", name, full, expected));
    endtask

    // a push counts only while full is low and a flush drops everything
    task automatic record_pushes();
        if (flush) begin
            sb_a.delete();
            sb_b.delete();
        end else begin
            if (push_a && !full_a) begin
                sb_a.push_back(data_a);
            end
            if (push_b && !full_b) begin
                sb_b.push_back(data_b);
            end
        end
    endtask

    // monitor on the falling edge where all DUT outputs are settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (prev_hold || prev_flush) begin
                assert (!out_valid) else
                    mismatch("beat after a cycle with hold or flush high");
            end
            check_beat();
            check_channel("A", int'(level_a), full_a, sb_a.size());
            check_channel("B", int'(level_b), full_b, sb_b.size());
            record_pushes();
        end
        prev_hold  = hold;
        prev_flush = flush;
    end

    task automatic check_idle(input string where);
        @(negedge clk);
        assert (!out_valid && !full_a && !full_b) else
            mismatch($sformatf("valid or full high %s", where));
        assert (level_a == '0 && level_b == '0) else
            mismatch($sformatf("levels %0d and %0d %s, expected 0", level_a, level_b, where));
    endtask

    task automatic wait_beats(input int target);
        int waited;
        waited = 0;
        while (beat_count < target && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (beat_count < target) begin
            fail_check("expected beats did not arrive in time");
        end
    endtask

    task automatic drain_queues();
        int waited;
        @(posedge clk);
        push_a <= 1'b0;
        push_b <= 1'b0;
        hold   <= 1'b0;
        waited = 0;
        while ((sb_a.size() > 0 || sb_b.size() > 0) && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (sb_a.size() > 0 || sb_b.size() > 0) begin
            fail_check("queues did not drain in time");
        end
    endtask

    task automatic finish_test(input string name, input int start);
        tests_run++;
        if (err_count == start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, err_count - start);
        end
    endtask

    task automatic reset_state_test();
        int start;
        start = err_count;
        check_idle("after reset");
        finish_test("reset state", start);
    endtask

    // both queues filled under hold and then released
    task automatic fairness_test();
        int start;
        int first;
        start = err_count;
        @(posedge clk);
        hold <= 1'b1;
        repeat (DEPTH) begin
            @(posedge clk);
            push_a <= 1'b1;
            data_a <= rand_word();
            push_b <= 1'b1;
            data_b <= rand_word();
        end
        @(posedge clk);
        push_a    <= 1'b0;
        push_b    <= 1'b0;
        hold      <= 1'b0;
        fair_next = 1'b0;
        fair_en   = 1'b1;
        first     = beat_count;
        wait_beats(first + 2 * DEPTH);
        fair_en = 1'b0;
        finish_test("fairness", start);
    endtask

    task automatic random_order_test();
        int start;
        start = err_count;
        repeat (RAND_CYCLES) begin
            @(posedge clk);
            push_a <= rand_bit();
            data_a <= rand_word();
            push_b <= rand_bit();
            data_b <= rand_word();
            hold   <= rand_bit() & rand_bit();
        end
        drain_queues();
        finish_test("random order", start);
    endtask

    // pushes past the depth while nothing is popped
    task automatic hold_level_test();
        int start;
        int i;
        start = err_count;
        @(posedge clk);
        hold <= 1'b1;
        for (i = 0; i < DEPTH + 2; i++) begin
            @(posedge clk);
            push_a <= 1'b1;
            data_a <= rand_word();
            push_b <= (i <= DEPTH);
            data_b <= rand_word();
        end
        @(posedge clk);
        push_a <= 1'b0;
        push_b <= 1'b0;
        @(posedge clk);
        assert (sb_a.size() == DEPTH && sb_b.size() == DEPTH) else
            fail_check("queues did not fill up to the depth under hold");
        drain_queues();
        finish_test("hold and level", start);
    endtask

    task automatic latency_test();
        int start;
        int first;
        int edges;
        start = err_count;
        @(posedge clk);
        push_b <= 1'b1;
        data_b <= rand_word();
        first  = beat_count;
        edges  = 0;
        while (beat_count == first && edges < WAIT_LIMIT) begin
            @(posedge clk);
            push_b <= 1'b0;
            if (beat_count == first) begin
                edges++;
            end
        end
        if (beat_count == first) begin
            fail_check("single word never reached the output");
        end else begin
            assert (edges == 2) else
                mismatch($sformatf("beat %0d edges after the push, expected 2", edges));
        end
        finish_test("latency", start);
    endtask

    task automatic flush_test();
        int start;
        int first;
        int i;
        start = err_count;
        @(posedge clk);
        hold <= 1'b1;
        for (i = 0; i < DEPTH; i++) begin
            @(posedge clk);
            push_a <= 1'b1;
            data_a <= merge_pkg::data_t'(16'hf000 + i);
            push_b <= 1'b1;
            data_b <= merge_pkg::data_t'(16'hf100 + i);
        end
        // release hold in the flush cycle so a pop races the flush
        @(posedge clk);
        push_a <= 1'b0;
        push_b <= 1'b0;
        hold   <= 1'b0;
        flush  <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        check_idle("after flush");
        @(posedge clk);
        push_a <= 1'b1;
        data_a <= FRESH_WORD;
        first  = beat_count;
        @(posedge clk);
        push_a <= 1'b0;
        wait_beats(first + 1);
        assert (last_beat.src == 1'b0 && last_beat.data == FRESH_WORD) else
            mismatch($sformatf("first beat after flush is %0d/%h, expected 0/%h",
                               last_beat.src, last_beat.data, FRESH_WORD));
        finish_test("flush", start);
    endtask

    initial begin
        seed   = 32'hd9ef_a5a6;
        flush  = 1'b0;
        hold   = 1'b0;
        push_a = 1'b0;
        push_b = 1'b0;
        data_a = '0;
        data_b = '0;
        wait (rst_n === 1'b1);
        @(posedge clk);
        reset_state_test();
        fairness_test();
        random_order_test();
        hold_level_test();
        latency_test();
        flush_test();
        $display("summary: %0d tests run, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, err_count);
        if (err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog against a stuck run
    initial begin
        #(WATCHDOG_CYCLES * PERIOD_NS);
        $display("watchdog expired before the tests completed");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+src
src/merge_pkg.sv
src/fifo_queue.sv
src/stream_merger.sv
src/dual_stream_merge_top.sv
verification/merge_clock_gen.sv
verification/merge_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the stream merger testbench with Verilator

set -u

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project root"
    exit 1
fi

BUILD_DIR=build
LOG_FILE="$BUILD_DIR/sim.log"
TOP=merge_tb

mkdir -p "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "cannot create $BUILD_DIR"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR/obj" \
    -o "V$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/obj/V$TOP" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qF '*** PASSED ***' "$LOG_FILE"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi
